//--- vlog.f
+incdir+verification
src/avl_tx_pkg.sv
src/sync_fifo.sv
src/a2p_addr_trans.sv
src/avl_slave_cntrl.sv
src/tx_credit_tracker.sv
src/tlp_tx_cntrl.sv
src/avl_tx_bridge.sv
verification/tb_avl_tx_bridge.sv

//--- Makefile
# Verilator build and run of the Avalon to PCIe TX bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_avl_tx_bridge
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All tests passed

SOURCES := $(wildcard src/*.sv verification/*.sv verification/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_pcie_model.svh
// Reference model for the bridge testbench, included into the testbench module
// Mirrors the page table, predicts every TLP beat in order and tracks credit use
`ifndef TB_PCIE_MODEL_SVH
`define TB_PCIE_MODEL_SVH

logic [63:0]           tbl_model [avl_tx_pkg::NUM_PAGES];
avl_tx_pkg::tx_beat_t  exp_beats [$];
bit                    exp_is_write [$];   // One entry per predicted TLP
int                    exp_pd_cost [$];
int                    tag_model;
int                    used_ph;
int                    used_pd;
int                    used_np;
int                    ret_ph;
int                    ret_pd;
int                    ret_np;

// Page base from the upper Avalon bits, page offset kept
function automatic logic [63:0] translate(input logic [19:0] avl_addr);
  logic [63:0] base;
  base = tbl_model[avl_addr[19:16]];
  return {base[63:16], avl_addr[15:0]};
endfunction

task automatic predict_tlp(input bit is_write, input logic [19:0] addr, input int len,
                           input logic [63:0] data [$]);
  logic [63:0]          pa;
  logic [31:0]          dw0;
  logic [31:0]          dw1;
  logic [7:0]           fmt;
  logic [7:0]           tag;
  bit                   addr32;
  avl_tx_pkg::tx_beat_t b;
  pa     = translate(addr);
  addr32 = (pa[63:32] == 32'h0);
  if (is_write)
    fmt = addr32 ? avl_tx_pkg::FMT_MWR32 : avl_tx_pkg::FMT_MWR64;
  else
    fmt = addr32 ? avl_tx_pkg::FMT_MRD32 : avl_tx_pkg::FMT_MRD64;
  tag = is_write ? 8'h00 : 8'(tag_model);
  if (!is_write)
    tag_model = (tag_model + 1) % 32;
  dw0 = {fmt, 14'h0, 10'(2 * len)};       // Length in DW
  dw1 = {bus_dev, 3'b000, tag, 8'hFF};
  b = '{valid: 1'b1, sop: 1'b1, eop: 1'b0, data: {dw1, dw0}};
  exp_beats.push_back(b);
  b.sop  = 1'b0;
  b.eop  = !is_write;
  b.data = addr32 ? {32'h0, pa[31:0]} : {pa[31:0], pa[63:32]};
  exp_beats.push_back(b);
  for (int i = 0; i < len && is_write; i++)
  begin
    b.eop  = (i == len - 1);
    b.data = data[i];
    exp_beats.push_back(b);
  end
  exp_is_write.push_back(is_write);
  exp_pd_cost.push_back(is_write ? (len + 1) / 2 : 0);
endtask

task automatic check_beat(input avl_tx_pkg::tx_beat_t got);
  avl_tx_pkg::tx_beat_t exp;
  bit                   is_wr;
  int                   pd;
  if (exp_beats.size() == 0)
    report_error("TX beat seen while no TLP was expected");
  else
  begin
    exp = exp_beats.pop_front();
    check_cnt++;
    if (got.sop !== exp.sop)
      report_mismatch("tx_o.sop", 64'(exp.sop), 64'(got.sop));
    if (got.eop !== exp.eop)
      report_mismatch("tx_o.eop", 64'(exp.eop), 64'(got.eop));
    if (got.data !== exp.data)
      report_mismatch("tx_o.data", exp.data, got.data);
    if (exp.sop)
    begin
      is_wr = exp_is_write.pop_front();
      pd    = exp_pd_cost.pop_front();
      if (is_wr)
      begin
        used_ph++;
        used_pd += pd;
      end
      else
        used_np++;
      if (used_ph > avl_tx_pkg::P_HDR_CREDITS + ret_ph)
        report_error("TLP started without a posted header credit");
      if (used_pd > avl_tx_pkg::P_DATA_CREDITS + ret_pd)
        report_error("TLP started without enough posted data credits");
      if (used_np > avl_tx_pkg::NP_HDR_CREDITS + ret_np)
        report_error("TLP started without a non-posted header credit");
    end
  end
endtask

`endif

//--- verification/tb_avl_tx_bridge.sv
// Testbench for the Avalon to PCIe TX bridge, random traffic checked against a model
// Built and run with the Makefile, ends with the error count and a verdict line
`timescale 1ns/1ps

module tb_avl_tx_bridge;

  localparam int NUM_TRANS      = 200;
  localparam int TIMEOUT_CYCLES = NUM_TRANS * 30 + 2000;

  logic                      avl_clk = 1'b0;
  logic                      rstn;
  avl_tx_pkg::avl_cmd_t      avl_cmd;
  logic [63:0]               avl_wdata;
  logic                      avl_waitreq;
  avl_tx_pkg::adtr_req_t     adtr;
  logic [31:0]               adtr_rdata;
  logic                      adtr_rvalid;
  logic [12:0]               bus_dev;
  avl_tx_pkg::cred_return_t  cred_ret;
  avl_tx_pkg::tx_beat_t      tx;
  logic                      tx_idle;

  int  seed     = 32'hcc02;
  int  ret_seed = 32'hcc02;      // Separate stream for credit returns
  int  err_cnt;
  int  check_cnt;
  int  cycle_cnt;
  int  last_sop_cycle;
  bit  rst_done;
  bit  returns_paused;

  task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                 input logic [63:0] got);
    err_cnt++;
    $display("[FAIL] t=%0t %s expected %h got %h", $time, sig, exp, got);
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("Error at t=%0t: %s", $time, msg);
  endtask

`include "tb_pcie_model.svh"

  avl_tx_bridge u_dut (
    .AvlClk_i(avl_clk), .Rstn_i(rstn),
    .avl_cmd_i(avl_cmd), .avl_wdata_i(avl_wdata), .avl_waitreq_o(avl_waitreq),
    .adtr_i(adtr), .adtr_rdata_o(adtr_rdata), .adtr_rvalid_o(adtr_rvalid),
    .bus_dev_i(bus_dev), .cred_ret_i(cred_ret),
    .tx_o(tx), .tx_idle_o(tx_idle)
  );

  always #10 avl_clk = ~avl_clk;

  always @(posedge avl_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, traffic did not drain", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  // Core returns only credits that TLPs have used
  always @(posedge avl_clk)
  begin
    logic [31:0] r;
    int          n;
    #2;
    cred_ret = '0;
    if (rst_done && !returns_paused)
    begin
      r = $random(ret_seed);
      if (r[2:0] == 3'd0 && used_ph > ret_ph)
      begin
        cred_ret.p_hdr = 1'b1;
        ret_ph++;
      end
      if (r[5:3] == 3'd0 && used_np > ret_np)
      begin
        cred_ret.np_hdr = 1'b1;
        ret_np++;
      end
      if (r[8:6] == 3'd0 && used_pd > ret_pd)
      begin
        n = int'(r[11:9]) + 1;
        if (n > used_pd - ret_pd)
          n = used_pd - ret_pd;
        cred_ret.p_data = 4'(n);
        ret_pd += n;
      end
    end
  end

  always @(negedge avl_clk)
  begin
    if (rst_done && tx.valid)
    begin
      if (tx.sop)
        last_sop_cycle = cycle_cnt;
      check_beat(tx);
    end
  end

  task automatic tick();
    @(posedge avl_clk);
    #2;
  endtask

  task automatic write_reg(input int idx, input logic [31:0] val);
    adtr = '{wr: 1'b1, rd: 1'b0, idx: 5'(idx), wdata: val};
    tick();
    adtr = '0;
  endtask

  task automatic read_reg(input int idx, input logic [31:0] exp);
    adtr = '{wr: 1'b0, rd: 1'b1, idx: 5'(idx), wdata: 32'h0};
    tick();
    adtr = '0;
    @(negedge avl_clk);
    check_cnt++;
    if (!adtr_rvalid)
      report_mismatch("adtr_rvalid_o", 64'd1, 64'd0);
    else if (adtr_rdata !== exp)
      report_mismatch("adtr_rdata_o", 64'(exp), 64'(adtr_rdata));
    tick();
  endtask

  // Holds the current cycle until waitrequest is low
  task automatic wait_accept();
    @(negedge avl_clk);
    while (avl_waitreq)
      @(negedge avl_clk);
    tick();
  endtask

  task automatic avl_write(input logic [19:0] addr, input int len);
    logic [63:0] data [$];
    logic [31:0] hi;
    logic [31:0] lo;
    for (int i = 0; i < len; i++)
    begin
      hi = $random(seed);
      lo = $random(seed);
      data.push_back({hi, lo});
      avl_cmd   = '{chipselect: 1'b1, read: 1'b0, write: 1'b1, address: addr,
                    burstcount: 4'(len)};
      avl_wdata = {hi, lo};
      wait_accept();
    end
    avl_cmd = '0;
    predict_tlp(1'b1, addr, len, data);
  endtask

  task automatic avl_read(input logic [19:0] addr, input int len);
    logic [63:0] none [$];
    avl_cmd = '{chipselect: 1'b1, read: 1'b1, write: 1'b0, address: addr,
                burstcount: 4'(len)};
    wait_accept();
    avl_cmd = '0;
    predict_tlp(1'b0, addr, len, none);
  endtask

  task automatic load_page_table();
    logic [31:0] lo;
    logic [31:0] hi;
    for (int i = 0; i < 32; i++)
      read_reg(i, 32'h0);                   // Reset value
    for (int p = 0; p < avl_tx_pkg::NUM_PAGES; p++)
    begin
      lo = $random(seed);
      hi = $random(seed);
      if (p % 2 == 0)
        hi = 32'h0;                         // 32-bit addressing pages
      tbl_model[p] = {hi, lo};
      write_reg(2 * p, lo);
      write_reg(2 * p + 1, hi);
    end
    for (int i = 0; i < 32; i++)
      read_reg(i, i[0] ? tbl_model[i / 2][63:32] : tbl_model[i / 2][31:0]);
  endtask

  // More posted headers queued than credits, output must stall
  task automatic check_credit_stall();
    logic [31:0] a;
    returns_paused = 1'b1;
    for (int i = 0; i < avl_tx_pkg::P_HDR_CREDITS + 4; i++)
    begin
      a = $random(seed);
      avl_write({a[19:3], 3'b000}, 1);
    end
    repeat (100) tick();
    @(negedge avl_clk);
    check_cnt++;
    if (tx_idle || cycle_cnt - last_sop_cycle < 50)
      report_error("TX output kept running while credit returns were paused");
    returns_paused = 1'b0;
    tick();
  endtask

  task automatic run_random_traffic(input int n);
    logic [31:0] r;
    logic [31:0] a;
    int          len;
    for (int t = 0; t < n; t++)
    begin
      r   = $random(seed);
      a   = $random(seed);
      len = int'(r[3:1]) + 1;
      if (r[0])
        avl_write({a[19:3], 3'b000}, len);
      else
        avl_read({a[19:3], 3'b000}, len);
      repeat (r[5:4]) tick();               // Idle gap
    end
  endtask

  initial
  begin
    logic [31:0] r;
    rstn      = 1'b0;
    avl_cmd   = '0;
    avl_wdata = '0;
    adtr      = '0;
    cred_ret  = '0;
    r         = $random(seed);
    bus_dev   = r[12:0];
    repeat (5) @(posedge avl_clk);
    #2;
    rstn     = 1'b1;
    rst_done = 1'b1;
    @(negedge avl_clk);
    check_cnt++;
    if (avl_waitreq || tx.valid || adtr_rvalid)
      report_error("outputs not idle after reset");
    tick();
    load_page_table();
    check_credit_stall();
    run_random_traffic(NUM_TRANS);
    while (exp_beats.size() != 0)
      tick();
    @(negedge avl_clk);
    check_cnt++;
    if (!tx_idle)
      report_mismatch("tx_idle_o", 64'd1, 64'd0);
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- src/avl_tx_bridge.sv
// Top of the Avalon to PCIe TX bridge
// Avalon requests in, memory read and write TLPs out on a credit paced 64-bit stream
`timescale 1ns/1ps

module avl_tx_bridge (
  input  logic                              AvlClk_i,
  input  logic                              Rstn_i,
  input  avl_tx_pkg::avl_cmd_t              avl_cmd_i,
  input  logic [avl_tx_pkg::DATA_W-1:0]     avl_wdata_i,
  output logic                              avl_waitreq_o,
  input  avl_tx_pkg::adtr_req_t             adtr_i,
  output logic [31:0]                       adtr_rdata_o,
  output logic                              adtr_rvalid_o,
  input  logic [12:0]                       bus_dev_i,
  input  avl_tx_pkg::cred_return_t          cred_ret_i,
  output avl_tx_pkg::tx_beat_t              tx_o,
  output logic                              tx_idle_o
);

  logic                                 trans_req;
  logic [avl_tx_pkg::AVL_ADDR_W-1:0]    trans_addr;
  logic                                 trans_vld;
  logic [63:0]                          pcie_addr;
  logic                                 cmd_push;
  logic                                 cmd_pop;
  avl_tx_pkg::pcie_cmd_t                cmd_in;
  avl_tx_pkg::pcie_cmd_t                cmd_head;
  logic                                 cmd_empty;
  logic [avl_tx_pkg::CMD_CNT_W-1:0]     cmd_free;
  logic                                 wrdat_push;
  logic                                 wrdat_pop;
  logic [avl_tx_pkg::DATA_W-1:0]        wrdat_head;
  logic [avl_tx_pkg::WRDAT_CNT_W-1:0]   wrdat_free;
  logic                                 consume;
  logic [3:0]                           consume_p_data;
  logic                                 consume_np;
  logic [avl_tx_pkg::CRED_W-1:0]        p_hdr_avail;
  logic [avl_tx_pkg::CRED_W-1:0]        p_data_avail;
  logic [avl_tx_pkg::CRED_W-1:0]        np_hdr_avail;

  avl_slave_cntrl u_slave (
    .AvlClk_i, .Rstn_i, .avl_cmd_i, .avl_waitreq_o,
    .wrdat_push_o(wrdat_push),
    .trans_req_o(trans_req), .trans_addr_o(trans_addr),
    .trans_vld_i(trans_vld), .pcie_addr_i(pcie_addr),
    .cmd_push_o(cmd_push), .cmd_o(cmd_in),
    .cmd_free_i(cmd_free), .wrdat_free_i(wrdat_free)
  );

  a2p_addr_trans u_addr_trans (
    .AvlClk_i, .Rstn_i,
    .trans_req_i(trans_req), .trans_addr_i(trans_addr),
    .trans_vld_o(trans_vld), .pcie_addr_o(pcie_addr),
    .adtr_i, .adtr_rdata_o, .adtr_rvalid_o
  );

  sync_fifo #(.WIDTH($bits(avl_tx_pkg::pcie_cmd_t)), .DEPTH(avl_tx_pkg::CMD_FIFO_DEPTH))
  u_cmd_fifo (
    .AvlClk_i, .Rstn_i, .push_i(cmd_push), .data_i(cmd_in), .pop_i(cmd_pop),
    .data_o(cmd_head), .empty_o(cmd_empty), .free_o(cmd_free)
  );

  sync_fifo #(.WIDTH(avl_tx_pkg::DATA_W), .DEPTH(avl_tx_pkg::WRDAT_FIFO_DEPTH))
  u_wrdat_fifo (
    .AvlClk_i, .Rstn_i, .push_i(wrdat_push), .data_i(avl_wdata_i), .pop_i(wrdat_pop),
    .data_o(wrdat_head), .empty_o(), .free_o(wrdat_free)   // Empty implied by cmd order
  );

  tx_credit_tracker u_credits (
    .AvlClk_i, .Rstn_i, .cred_ret_i,
    .consume_i(consume), .consume_p_data_i(consume_p_data), .consume_np_i(consume_np),
    .p_hdr_avail_o(p_hdr_avail), .p_data_avail_o(p_data_avail), .np_hdr_avail_o(np_hdr_avail)
  );

  tlp_tx_cntrl u_tlp_tx (
    .AvlClk_i, .Rstn_i,
    .cmd_i(cmd_head), .cmd_empty_i(cmd_empty), .cmd_pop_o(cmd_pop),
    .wrdat_i(wrdat_head), .wrdat_pop_o(wrdat_pop),
    .p_hdr_avail_i(p_hdr_avail), .p_data_avail_i(p_data_avail), .np_hdr_avail_i(np_hdr_avail),
    .consume_o(consume), .consume_p_data_o(consume_p_data), .consume_np_o(consume_np),
    .bus_dev_i, .tx_o, .tx_idle_o
  );

endmodule

//--- src/tlp_tx_cntrl.sv
// Turns queued commands into memory read and write TLPs on the TX stream
// Two header beats, then write data, started only when credits cover the TLP
`timescale 1ns/1ps

module tlp_tx_cntrl (
  input  logic                            AvlClk_i,
  input  logic                            Rstn_i,
  input  avl_tx_pkg::pcie_cmd_t           cmd_i,
  input  logic                            cmd_empty_i,
  output logic                            cmd_pop_o,
  input  logic [avl_tx_pkg::DATA_W-1:0]   wrdat_i,
  output logic                            wrdat_pop_o,
  input  logic [avl_tx_pkg::CRED_W-1:0]   p_hdr_avail_i,
  input  logic [avl_tx_pkg::CRED_W-1:0]   p_data_avail_i,
  input  logic [avl_tx_pkg::CRED_W-1:0]   np_hdr_avail_i,
  output logic                            consume_o,
  output logic [3:0]                      consume_p_data_o,
  output logic                            consume_np_o,
  input  logic [12:0]                     bus_dev_i,
  output avl_tx_pkg::tx_beat_t            tx_o,
  output logic                            tx_idle_o
);

  typedef enum logic [1:0] {S_IDLE, S_HDR0, S_HDR1, S_DATA} state_e;

  state_e                            state;
  avl_tx_pkg::pcie_cmd_t             cmd_q;
  logic [avl_tx_pkg::BURST_W-1:0]    data_cnt;
  logic [avl_tx_pkg::TAG_W-1:0]      tag_cnt;
  logic [3:0]                        pd_cost;
  logic                              cred_ok;
  logic                              start;
  logic                              addr64;
  logic [7:0]                        fmt;
  logic [7:0]                        tag;
  logic [9:0]                        len_dw;

  // One data credit covers two qwords
  assign pd_cost = (cmd_i.len >> 1) + cmd_i.len[0];
  assign cred_ok = cmd_i.is_write ?
                   (p_hdr_avail_i != '0 && p_data_avail_i >= (avl_tx_pkg::CRED_W)'(pd_cost)) :
                   (np_hdr_avail_i != '0);
  assign start   = (state == S_IDLE) & ~cmd_empty_i & cred_ok;

  assign cmd_pop_o        = start;
  assign consume_o        = start;
  assign consume_np_o     = ~cmd_i.is_write;
  assign consume_p_data_o = cmd_i.is_write ? pd_cost : 4'h0;

  assign addr64 = |cmd_q.addr[63:32];           // 3DW header when upper half is zero
  assign len_dw = 10'({cmd_q.len, 1'b0});
  assign tag    = cmd_q.is_write ? 8'h00 : 8'(tag_cnt);

  always_comb
  begin
    if (cmd_q.is_write)
      fmt = addr64 ? avl_tx_pkg::FMT_MWR64 : avl_tx_pkg::FMT_MWR32;
    else
      fmt = addr64 ? avl_tx_pkg::FMT_MRD64 : avl_tx_pkg::FMT_MRD32;
  end

  always_comb
  begin
    tx_o = '0;
    case (state)
      S_HDR0:
      begin
        tx_o.valid = 1'b1;
        tx_o.sop   = 1'b1;
        tx_o.data  = {bus_dev_i, 3'b000, tag, 8'hFF, fmt, 14'h0, len_dw};
      end
      S_HDR1:
      begin
        tx_o.valid = 1'b1;
        tx_o.eop   = ~cmd_q.is_write;           // Reads end on the address beat
        tx_o.data  = addr64 ? {cmd_q.addr[31:0], cmd_q.addr[63:32]} :
                              {32'h0, cmd_q.addr[31:0]};
      end
      S_DATA:
      begin
        tx_o.valid = 1'b1;
        tx_o.eop   = (data_cnt == '0);
        tx_o.data  = wrdat_i;
      end
      default: tx_o = '0;
    endcase
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state    <= S_IDLE;
      data_cnt <= '0;
      tag_cnt  <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (start)
          begin
            state    <= S_HDR0;
            data_cnt <= cmd_i.len - 1'b1;       // Beats left after the current one
          end
        S_HDR0:
        begin
          state <= S_HDR1;
          if (!cmd_q.is_write)
            tag_cnt <= tag_cnt + 1'b1;          // Wraps modulo 32
        end
        S_HDR1: state <= cmd_q.is_write ? S_DATA : S_IDLE;
        default:
        begin
          data_cnt <= data_cnt - 1'b1;
          if (data_cnt == '0)
            state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (start)
      cmd_q <= cmd_i;
  end

  assign wrdat_pop_o = (state == S_DATA);
  assign tx_idle_o   = cmd_empty_i & (state == S_IDLE);

endmodule

//--- src/tx_credit_tracker.sv
// Available posted header, posted data and non-posted header credits
// Returns from the core add, TLP starts subtract, both in the same cycle
`timescale 1ns/1ps

module tx_credit_tracker (
  input  logic                            AvlClk_i,
  input  logic                            Rstn_i,
  input  avl_tx_pkg::cred_return_t        cred_ret_i,
  input  logic                            consume_i,
  input  logic [3:0]                      consume_p_data_i,
  input  logic                            consume_np_i,
  output logic [avl_tx_pkg::CRED_W-1:0]   p_hdr_avail_o,
  output logic [avl_tx_pkg::CRED_W-1:0]   p_data_avail_o,
  output logic [avl_tx_pkg::CRED_W-1:0]   np_hdr_avail_o
);

  // Clamps to zero and to the counter maximum
  function automatic logic [avl_tx_pkg::CRED_W-1:0] sat_update(
    input logic [avl_tx_pkg::CRED_W-1:0] cur,
    input logic [3:0]                    add,
    input logic [3:0]                    sub
  );
    logic [avl_tx_pkg::CRED_W:0] sum;
    sum = {1'b0, cur} + (avl_tx_pkg::CRED_W + 1)'(add);
    if (sum < (avl_tx_pkg::CRED_W + 1)'(sub))
      return '0;
    sum = sum - (avl_tx_pkg::CRED_W + 1)'(sub);
    if (sum[avl_tx_pkg::CRED_W])
      return '1;
    return sum[avl_tx_pkg::CRED_W-1:0];
  endfunction

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      p_hdr_avail_o  <= (avl_tx_pkg::CRED_W)'(avl_tx_pkg::P_HDR_CREDITS);
      p_data_avail_o <= (avl_tx_pkg::CRED_W)'(avl_tx_pkg::P_DATA_CREDITS);
      np_hdr_avail_o <= (avl_tx_pkg::CRED_W)'(avl_tx_pkg::NP_HDR_CREDITS);
    end
    else
    begin
      p_hdr_avail_o  <= sat_update(p_hdr_avail_o, {3'b000, cred_ret_i.p_hdr},
                                   {3'b000, consume_i & ~consume_np_i});
      p_data_avail_o <= sat_update(p_data_avail_o, cred_ret_i.p_data,
                                   consume_i ? consume_p_data_i : 4'h0);
      np_hdr_avail_o <= sat_update(np_hdr_avail_o, {3'b000, cred_ret_i.np_hdr},
                                   {3'b000, consume_i & consume_np_i});
    end
  end

endmodule

//--- src/avl_slave_cntrl.sv
// Avalon-MM slave front end, takes write bursts and reads under waitrequest
// Each finished request is translated and pushed as one command two cycles later
`timescale 1ns/1ps

module avl_slave_cntrl (
  input  logic                                AvlClk_i,
  input  logic                                Rstn_i,
  input  avl_tx_pkg::avl_cmd_t                avl_cmd_i,
  output logic                                avl_waitreq_o,
  output logic                                wrdat_push_o,
  output logic                                trans_req_o,
  output logic [avl_tx_pkg::AVL_ADDR_W-1:0]   trans_addr_o,
  input  logic                                trans_vld_i,
  input  logic [63:0]                         pcie_addr_i,
  output logic                                cmd_push_o,
  output avl_tx_pkg::pcie_cmd_t               cmd_o,
  input  logic [avl_tx_pkg::CMD_CNT_W-1:0]    cmd_free_i,
  input  logic [avl_tx_pkg::WRDAT_CNT_W-1:0]  wrdat_free_i
);

  typedef enum logic [1:0] {S_IDLE, S_WR_BURST, S_TRANS} state_e;

  state_e                             state;
  logic [avl_tx_pkg::BURST_W-1:0]     beats_left;
  logic [avl_tx_pkg::AVL_ADDR_W-1:0]  addr_q;
  logic [avl_tx_pkg::BURST_W-1:0]     len_q;
  logic                               is_write_q;
  logic                               accept;
  logic                               last_beat;

  always_comb
  begin
    avl_waitreq_o = 1'b0;
    if (state == S_TRANS)
      avl_waitreq_o = 1'b1;                   // Translation in flight
    else if (state == S_IDLE)
    begin
      // One slot for this request, one for the command still being pushed
      if (cmd_free_i < (avl_tx_pkg::CMD_CNT_W)'(2))
        avl_waitreq_o = 1'b1;
      else if (avl_cmd_i.write &&
               wrdat_free_i < (avl_tx_pkg::WRDAT_CNT_W)'(avl_cmd_i.burstcount))
        avl_waitreq_o = 1'b1;                 // Whole burst must fit
    end
  end

  assign accept = avl_cmd_i.chipselect & (avl_cmd_i.read | avl_cmd_i.write) & ~avl_waitreq_o;

  always_comb
  begin
    if (state == S_IDLE)
      last_beat = accept & (avl_cmd_i.read | (avl_cmd_i.burstcount == 1));
    else
      last_beat = accept & avl_cmd_i.write & (beats_left == 1);
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state      <= S_IDLE;
      beats_left <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (accept)
          begin
            beats_left <= avl_cmd_i.burstcount - 1'b1;
            state      <= last_beat ? S_TRANS : S_WR_BURST;
          end
        S_WR_BURST:
          if (wrdat_push_o)
          begin
            beats_left <= beats_left - 1'b1;
            if (last_beat)
              state <= S_TRANS;
          end
        default: state <= S_IDLE;            // Translate lasts one cycle
      endcase
    end
  end

  // Request fields come from the first beat
  always_ff @(posedge AvlClk_i)
  begin
    if (state == S_IDLE && accept)
    begin
      addr_q     <= avl_cmd_i.address;
      len_q      <= avl_cmd_i.burstcount;
      is_write_q <= avl_cmd_i.write;
    end
  end

  assign wrdat_push_o = accept & avl_cmd_i.write;
  assign trans_req_o  = (state == S_TRANS);
  assign trans_addr_o = addr_q;
  assign cmd_push_o   = trans_vld_i;
  assign cmd_o        = '{is_write: is_write_q, addr: pcie_addr_i, len: len_q};

endmodule

//--- src/a2p_addr_trans.sv
// Avalon to PCIe page table with a 32-bit register port
// Translates the upper address bits to a 64-bit PCIe base in one cycle
`timescale 1ns/1ps

module a2p_addr_trans (
  input  logic                               AvlClk_i,
  input  logic                               Rstn_i,
  input  logic                               trans_req_i,
  input  logic [avl_tx_pkg::AVL_ADDR_W-1:0]  trans_addr_i,
  output logic                               trans_vld_o,
  output logic [63:0]                        pcie_addr_o,
  input  avl_tx_pkg::adtr_req_t              adtr_i,
  output logic [31:0]                        adtr_rdata_o,
  output logic                               adtr_rvalid_o
);

  logic [63:0] page_tbl [avl_tx_pkg::NUM_PAGES];
  logic [63:0] page_base;
  logic [63:0] reg_entry;

  assign page_base = page_tbl[trans_addr_i[avl_tx_pkg::AVL_ADDR_W-1:avl_tx_pkg::PASS_THRU_BITS]];
  assign reg_entry = page_tbl[adtr_i.idx[4:1]];

  // Table writes, one 32-bit half at a time
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      for (int i = 0; i < avl_tx_pkg::NUM_PAGES; i++)
        page_tbl[i] <= '0;
    end
    else if (adtr_i.wr)
    begin
      if (adtr_i.idx[0])
        page_tbl[adtr_i.idx[4:1]][63:32] <= adtr_i.wdata;
      else
        page_tbl[adtr_i.idx[4:1]][31:0]  <= adtr_i.wdata;
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      trans_vld_o   <= 1'b0;
      adtr_rvalid_o <= 1'b0;
    end
    else
    begin
      trans_vld_o   <= trans_req_i;
      adtr_rvalid_o <= adtr_i.rd;
    end
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (trans_req_i)
      pcie_addr_o <= {page_base[63:avl_tx_pkg::PASS_THRU_BITS],
                      trans_addr_i[avl_tx_pkg::PASS_THRU_BITS-1:0]};  // Offset in page
    if (adtr_i.rd)
      adtr_rdata_o <= adtr_i.idx[0] ? reg_entry[63:32] : reg_entry[31:0];
  end

endmodule

//--- src/sync_fifo.sv
// Single clock show-ahead FIFO, head word visible one cycle after its push
// Reports free words so the writer can reserve space ahead
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 16          // Power of two
) (
  input  logic                     AvlClk_i,
  input  logic                     Rstn_i,
  input  logic                     push_i,
  input  logic [WIDTH-1:0]         data_i,
  input  logic                     pop_i,
  output logic [WIDTH-1:0]         data_o,
  output logic                     empty_o,
  output logic [$clog2(DEPTH):0]   free_o
);

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH):0]     count;

  always_ff @(posedge AvlClk_i)
  begin
    if (push_i)
      mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;     // Wraps at DEPTH
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
      if (push_i && !pop_i)
        count <= count + 1'b1;
      else if (pop_i && !push_i)
        count <= count - 1'b1;
    end
  end

  assign data_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign free_o  = ($clog2(DEPTH) + 1)'(DEPTH) - count;

endmodule

//--- src/avl_tx_pkg.sv
// Shared widths, limits, TLP codes and bus structs of the Avalon to PCIe TX bridge
// Every bridge file refers to these by avl_tx_pkg:: scoped names
package avl_tx_pkg;

  // Avalon side
  localparam int AVL_ADDR_W     = 20;
  localparam int PASS_THRU_BITS = 16;   // Low bits kept as is
  localparam int NUM_PAGES      = 16;
  localparam int BURST_W        = 4;    // Bursts of 1 to 8 qwords
  localparam int DATA_W         = 64;

  // Queue depths and their free count widths
  localparam int CMD_FIFO_DEPTH   = 16;
  localparam int WRDAT_FIFO_DEPTH = 64;
  localparam int CMD_CNT_W        = $clog2(CMD_FIFO_DEPTH) + 1;
  localparam int WRDAT_CNT_W      = $clog2(WRDAT_FIFO_DEPTH) + 1;

  // Flow control limits advertised by the core
  localparam int P_HDR_CREDITS  = 8;
  localparam int P_DATA_CREDITS = 32;
  localparam int NP_HDR_CREDITS = 4;
  localparam int CRED_W         = 8;

  localparam int TAG_W = 5;

  // Format and type byte of DW0
  localparam logic [7:0] FMT_MWR32 = 8'h40;
  localparam logic [7:0] FMT_MWR64 = 8'h60;
  localparam logic [7:0] FMT_MRD32 = 8'h00;
  localparam logic [7:0] FMT_MRD64 = 8'h20;

  typedef struct packed {
    logic                  chipselect;
    logic                  read;
    logic                  write;
    logic [AVL_ADDR_W-1:0] address;     // Byte address
    logic [BURST_W-1:0]    burstcount;
  } avl_cmd_t;

  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [4:0]  idx;                   // Entry * 2, bit 0 picks the high word
    logic [31:0] wdata;
  } adtr_req_t;

  typedef struct packed {
    logic               is_write;
    logic [63:0]        addr;
    logic [BURST_W-1:0] len;            // In qwords
  } pcie_cmd_t;

  typedef struct packed {
    logic              valid;
    logic              sop;
    logic              eop;
    logic [DATA_W-1:0] data;
  } tx_beat_t;

  typedef struct packed {
    logic       p_hdr;
    logic [3:0] p_data;
    logic       np_hdr;
  } cred_return_t;

endpackage
